//--- tb.f
+incdir+include
hw/tl_pkg.sv
hw/tl_if.sv
hw/dcache_tag_array.sv
hw/store_buffer.sv
hw/tl_hazard_ctrl.sv
hw/tl_stage_reg.sv
hw/tl_stage.sv
sim/tl_stage_tb.sv

//--- Bender.yml
package:
  name: tl_stage

export_include_dirs:
  - include

sources:
  - hw/tl_pkg.sv
  - hw/tl_if.sv
  - hw/dcache_tag_array.sv
  - hw/store_buffer.sv
  - hw/tl_hazard_ctrl.sv
  - hw/tl_stage_reg.sv
  - hw/tl_stage.sv
  - target: simulation
    files:
      - sim/tl_stage_tb.sv

//--- sim/tl_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tl_defs.svh"

module tl_stage_tb;
    import tl_pkg::*;

    localparam int NumLines = 1 << `TL_INDEX_W;
    localparam int NumTxn   = 400;
    localparam int MaxWait  = 200;
    localparam int TagLsb   = `TL_OFFSET_W + `TL_INDEX_W;

    logic      clk_i;
    logic      arst_n_i;
    logic      memop_rd_i;
    logic      memop_wr_i;
    addr_t     addr_i;
    data_t     st_data_i;
    mem_size_e size_i;
    logic      rf_we_i;
    reg_addr_t rf_waddr_i;
    logic      store_permission_i;
    logic      fill_i;
    addr_t     fill_addr_i;
    logic      stall_o;
    logic      miss_o;
    addr_t     miss_addr_o;
    addr_t     addr_o;
    index_t    index_o;
    logic      mem_rd_o;
    logic      cache_hit_o;
    logic      sb_hit_o;
    data_t     load_data_o;
    logic      rf_we_o;
    reg_addr_t rf_waddr_o;
    logic      drain_o;
    addr_t     drain_addr_o;
    data_t     drain_data_o;
    mem_size_e drain_size_o;
    logic      merge_o;

    // Request as upstream presents it
    logic      cur_rd;
    logic      cur_wr;
    addr_t     cur_addr;
    data_t     cur_data;
    mem_size_e cur_size;
    logic      cur_rf_we;
    reg_addr_t cur_rf_waddr;

    // Reference model of tag array, store queue and controller
    logic [NumLines-1:0] m_valid;
    tag_t                m_tag [NumLines];
    addr_t               sb_addr [$];
    data_t               sb_data [$];
    mem_size_e           sb_size [$];
    tl_state_e           m_state;

    // Registered outputs expected after the next edge
    logic      e_mem_rd;
    logic      e_cache_hit;
    logic      e_sb_hit;
    data_t     e_load_data;
    logic      e_rf_we;
    reg_addr_t e_rf_waddr;
    logic      e_merge;
    logic      e_drain;
    addr_t     e_drain_addr;
    data_t     e_drain_data;
    mem_size_e e_drain_size;
    addr_t     e_addr;
    index_t    e_index;
    logic      e_addr_known;

    int          fill_cnt;
    addr_t       fill_line;
    logic [31:0] lfsr_q;
    int          mismatch_count;
    int          timeout_count;
    logic        aborted;

    tl_stage i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BC_D35C;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Eight word addresses over three lines with two lines on index 0
    function automatic addr_t pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_1000;
            3'd1:    return 32'h0000_1004;
            3'd2:    return 32'h0000_1008;
            3'd3:    return 32'h0000_2010;
            3'd4:    return 32'h0000_2018;
            3'd5:    return 32'h0000_201C;
            3'd6:    return 32'h0000_3000;
            default: return 32'h0000_300C;
        endcase
    endfunction

    function automatic mem_size_e pick_size(input logic [1:0] sel);
        case (sel)
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input mem_size_e got, input mem_size_e exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_index(input index_t got, input index_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs;
        check_bit(mem_rd_o, e_mem_rd, "mem_rd_o");
        check_bit(cache_hit_o, e_cache_hit, "cache_hit_o");
        check_bit(sb_hit_o, e_sb_hit, "sb_hit_o");
        check_bit(rf_we_o, e_rf_we, "rf_we_o");
        check_bit(merge_o, e_merge, "merge_o");
        check_bit(drain_o, e_drain, "drain_o");
        if (e_sb_hit) begin
            check_data(load_data_o, e_load_data, "load_data_o");
        end
        if (e_rf_we) begin
            check_reg(rf_waddr_o, e_rf_waddr, "rf_waddr_o");
        end
        if (e_addr_known) begin
            check_addr(addr_o, e_addr, "addr_o");
            check_index(index_o, e_index, "index_o");
        end
        if (e_drain) begin
            check_addr(drain_addr_o, e_drain_addr, "drain_addr_o");
            check_data(drain_data_o, e_drain_data, "drain_data_o");
            check_size(drain_size_o, e_drain_size, "drain_size_o");
        end
    endtask

    // Predict this cycle's stall and miss, then advance the model past the edge
    task automatic model_cycle;
        index_t    idx;
        tag_t      tg;
        addr_t     line;
        logic      c_hit;
        logic      any_match;
        logic      s_hit;
        logic      mrg;
        logic      full;
        logic      stall;
        logic      miss;
        logic      drn;
        int        j;
        int        i;
        tl_state_e nxt;

        idx   = addr_i[`TL_OFFSET_W +: `TL_INDEX_W];
        tg    = tag_t'(addr_i >> TagLsb);
        line  = (addr_i >> `TL_OFFSET_W) << `TL_OFFSET_W;
        c_hit = (memop_rd_i || memop_wr_i) && m_valid[idx] && (m_tag[idx] == tg);
        any_match = 1'b0;
        j = 0;
        // Later queue entries are newer
        for (i = 0; i < sb_addr.size(); i++) begin
            if (sb_addr[i] == addr_i && sb_size[i] == size_i) begin
                any_match = 1'b1;
                j = i;
            end
        end
        s_hit = memop_rd_i && any_match;
        mrg   = memop_wr_i && any_match;
        full  = (sb_addr.size() == `TL_SB_DEPTH);
        stall = 1'b0;
        miss  = 1'b0;
        drn   = 1'b0;
        nxt   = m_state;
        case (m_state)
            TL_IDLE: begin
                if (memop_rd_i && !c_hit && !s_hit) begin
                    stall = 1'b1;
                    miss  = 1'b1;
                    nxt   = HAZARD_DC_MISS;
                end else if (memop_wr_i && full && !mrg) begin
                    stall = 1'b1;
                    nxt   = HAZARD_SB_FULL;
                end else if (!memop_rd_i && !memop_wr_i) begin
                    drn = store_permission_i;
                end
            end
            HAZARD_DC_MISS: begin
                stall = 1'b1;
                if (fill_i) begin
                    nxt = TL_IDLE;
                end
            end
            default: begin
                stall = 1'b1;
                drn   = store_permission_i;
                if (drn && sb_addr.size() != 0) begin
                    nxt = TL_IDLE;
                end
            end
        endcase

        check_bit(stall_o, stall, "stall_o");
        check_bit(miss_o, miss, "miss_o");
        if (miss) begin
            check_addr(miss_addr_o, line, "miss_addr_o");
            fill_cnt  = 1 + int'(take_bits(3));
            fill_line = line;
        end

        e_drain = drn && (sb_addr.size() != 0);
        if (sb_addr.size() != 0) begin
            e_drain_addr = sb_addr[0];
            e_drain_data = sb_data[0];
            e_drain_size = sb_size[0];
        end
        if (!stall) begin
            e_mem_rd     = memop_rd_i && !s_hit;
            e_cache_hit  = c_hit;
            e_sb_hit     = s_hit;
            e_load_data  = s_hit ? sb_data[j] : '0;
            e_rf_we      = rf_we_i;
            e_rf_waddr   = rf_waddr_i;
            e_merge      = mrg;
            e_addr       = addr_i;
            e_index      = idx;
            e_addr_known = 1'b1;
        end else begin
            e_mem_rd = 1'b0;
            e_rf_we  = 1'b0;
            e_merge  = 1'b0;
        end

        // Merge, then drain the oldest, then append
        if (mrg && !stall) begin
            sb_data[j] = st_data_i;
        end
        if (e_drain) begin
            sb_addr.delete(0);
            sb_data.delete(0);
            sb_size.delete(0);
        end
        if (memop_wr_i && !any_match && !stall && sb_addr.size() < `TL_SB_DEPTH) begin
            sb_addr.push_back(addr_i);
            sb_data.push_back(st_data_i);
            sb_size.push_back(size_i);
        end
        if (fill_i) begin
            m_valid[fill_addr_i[`TL_OFFSET_W +: `TL_INDEX_W]] = 1'b1;
            m_tag[fill_addr_i[`TL_OFFSET_W +: `TL_INDEX_W]]   = tag_t'(fill_addr_i >> TagLsb);
        end
        m_state = nxt;
    endtask

    task automatic step_cycle;
        @(negedge clk_i);
        check_outputs();
        fill_i = 1'b0;
        if (fill_cnt > 0) begin
            fill_cnt--;
            if (fill_cnt == 0) begin
                fill_i      = 1'b1;
                fill_addr_i = fill_line;
            end
        end
        store_permission_i = (take_bits(1) != 0);
        memop_rd_i = cur_rd;
        memop_wr_i = cur_wr;
        addr_i     = cur_addr;
        st_data_i  = cur_data;
        size_i     = cur_size;
        rf_we_i    = cur_rf_we;
        rf_waddr_i = cur_rf_waddr;
        #1;
        model_cycle();
    endtask

    task automatic run_request(input logic is_load, input addr_t a, input data_t d,
                               input mem_size_e s, input reg_addr_t wa);
        int waited;
        cur_rd       = is_load;
        cur_wr       = !is_load;
        cur_addr     = a;
        cur_data     = d;
        cur_size     = s;
        cur_rf_we    = is_load;
        cur_rf_waddr = wa;
        waited       = 0;
        step_cycle();
        // Request stays on the inputs while the stage stalls
        while (stall_o === 1'b1) begin
            if (waited == MaxWait) begin
                $display("ERROR at %0t: stall_o still high after %0d cycles", $time, MaxWait);
                timeout_count++;
                aborted = 1'b1;
                break;
            end
            waited++;
            step_cycle();
        end
        cur_rd    = 1'b0;
        cur_wr    = 1'b0;
        cur_rf_we = 1'b0;
    endtask

    initial begin : main_seq
        int          n;
        int          gap;
        logic [31:0] rnd;
        logic        is_load;
        addr_t       a;
        data_t       d;
        mem_size_e   s;
        reg_addr_t   wa;

        lfsr_q         = 32'd87;
        mismatch_count = 0;
        timeout_count  = 0;
        aborted        = 1'b0;
        fill_cnt       = 0;
        fill_line      = '0;
        m_valid        = '0;
        m_state        = TL_IDLE;
        {e_mem_rd, e_cache_hit, e_sb_hit, e_rf_we, e_merge, e_drain} = '0;
        e_addr_known   = 1'b0;
        memop_rd_i         = 1'b0;
        memop_wr_i         = 1'b0;
        addr_i             = '0;
        st_data_i          = '0;
        size_i             = SIZE_WORD;
        rf_we_i            = 1'b0;
        rf_waddr_i         = '0;
        store_permission_i = 1'b0;
        fill_i             = 1'b0;
        fill_addr_i        = '0;
        cur_rd       = 1'b0;
        cur_wr       = 1'b0;
        cur_addr     = '0;
        cur_data     = '0;
        cur_size     = SIZE_WORD;
        cur_rf_we    = 1'b0;
        cur_rf_waddr = '0;

        arst_n_i = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        #1;
        // Control outputs right after reset
        check_bit(stall_o, 1'b0, "stall_o after reset");
        check_bit(miss_o, 1'b0, "miss_o after reset");
        check_bit(mem_rd_o, 1'b0, "mem_rd_o after reset");
        check_bit(sb_hit_o, 1'b0, "sb_hit_o after reset");
        check_bit(rf_we_o, 1'b0, "rf_we_o after reset");
        check_bit(drain_o, 1'b0, "drain_o after reset");
        check_bit(merge_o, 1'b0, "merge_o after reset");

        for (n = 0; n < NumTxn && !aborted; n++) begin
            rnd = take_bits(2);
            gap = int'(rnd);
            repeat (gap) step_cycle();
            // First request is a load on the empty cache
            rnd     = take_bits(2);
            is_load = (n == 0) || (rnd[1] == 1'b0);
            rnd     = take_bits(3);
            a       = pick_addr(rnd[2:0]);
            d       = take_bits(32);
            rnd     = take_bits(2);
            s       = pick_size(rnd[1:0]);
            rnd     = take_bits(5);
            wa      = rnd[4:0];
            run_request(is_load, a, d, s, wa);
        end
        if (!aborted) begin
            step_cycle();
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/tl_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "tl_defs.svh"

module tl_stage (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,
    input  wire logic               memop_rd_i,
    input  wire logic               memop_wr_i,
    input  wire tl_pkg::addr_t      addr_i,
    input  wire tl_pkg::data_t      st_data_i,
    input  wire tl_pkg::mem_size_e  size_i,
    input  wire logic               rf_we_i,
    input  wire tl_pkg::reg_addr_t  rf_waddr_i,
    input  wire logic               store_permission_i,
    input  wire logic               fill_i,
    input  wire tl_pkg::addr_t      fill_addr_i,
    output logic                    stall_o,
    output logic                    miss_o,
    output tl_pkg::addr_t           miss_addr_o,
    output tl_pkg::addr_t           addr_o,
    output tl_pkg::index_t          index_o,
    output logic                    mem_rd_o,
    output logic                    cache_hit_o,
    output logic                    sb_hit_o,
    output tl_pkg::data_t           load_data_o,
    output logic                    rf_we_o,
    output tl_pkg::reg_addr_t       rf_waddr_o,
    output logic                    drain_o,
    output tl_pkg::addr_t           drain_addr_o,
    output tl_pkg::data_t           drain_data_o,
    output tl_pkg::mem_size_e       drain_size_o,
    output logic                    merge_o
);
    import tl_pkg::*;

    tl_req_if   req_if ();
    tl_drain_if drain_if ();

    logic   cache_hit;
    logic   sb_hit;
    data_t  sb_load_data;
    index_t tag_index;

    assign req_if.rd   = memop_rd_i;
    assign req_if.wr   = memop_wr_i;
    assign req_if.addr = addr_i;
    assign req_if.data = st_data_i;
    assign req_if.size = size_i;

    // Line address of the missing load
    assign miss_addr_o = {addr_i[`TL_ADDR_W-1:`TL_OFFSET_W], {`TL_OFFSET_W{1'b0}}};

    dcache_tag_array i_tag_array (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_if),
        .fill_i      (fill_i),
        .fill_addr_i (fill_addr_i),
        .hit_o       (cache_hit),
        .index_o     (tag_index)
    );

    store_buffer i_store_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_if),
        .stall_i     (stall_o),
        .drain_io    (drain_if),
        .hit_o       (sb_hit),
        .load_data_o (sb_load_data)
    );

    tl_hazard_ctrl i_hazard_ctrl (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .req_i              (req_if),
        .cache_hit_i        (cache_hit),
        .sb_hit_i           (sb_hit),
        .drain_io           (drain_if),
        .store_permission_i (store_permission_i),
        .fill_i             (fill_i),
        .stall_o            (stall_o),
        .miss_o             (miss_o)
    );

    tl_stage_reg i_stage_reg (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req_if),
        .drain_i      (drain_if),
        .stall_i      (stall_o),
        .cache_hit_i  (cache_hit),
        .index_i      (tag_index),
        .sb_hit_i     (sb_hit),
        .load_data_i  (sb_load_data),
        .rf_we_i      (rf_we_i),
        .rf_waddr_i   (rf_waddr_i),
        .addr_o       (addr_o),
        .index_o      (index_o),
        .mem_rd_o     (mem_rd_o),
        .cache_hit_o  (cache_hit_o),
        .sb_hit_o     (sb_hit_o),
        .load_data_o  (load_data_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .drain_o      (drain_o),
        .drain_addr_o (drain_addr_o),
        .drain_data_o (drain_data_o),
        .drain_size_o (drain_size_o),
        .merge_o      (merge_o)
    );

endmodule

`default_nettype wire

//--- hw/tl_stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module tl_stage_reg (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,
    tl_req_if.sink                  req_i,
    tl_drain_if.sink                drain_i,
    input  wire logic               stall_i,
    input  wire logic               cache_hit_i,
    input  wire tl_pkg::index_t     index_i,
    input  wire logic               sb_hit_i,
    input  wire tl_pkg::data_t      load_data_i,
    input  wire logic               rf_we_i,
    input  wire tl_pkg::reg_addr_t  rf_waddr_i,
    output tl_pkg::addr_t           addr_o,
    output tl_pkg::index_t          index_o,
    output logic                    mem_rd_o,
    output logic                    cache_hit_o,
    output logic                    sb_hit_o,
    output tl_pkg::data_t           load_data_o,
    output logic                    rf_we_o,
    output tl_pkg::reg_addr_t       rf_waddr_o,
    output logic                    drain_o,
    output tl_pkg::addr_t           drain_addr_o,
    output tl_pkg::data_t           drain_data_o,
    output tl_pkg::mem_size_e       drain_size_o,
    output logic                    merge_o
);
    import tl_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_rd_o    <= 1'b0;
            cache_hit_o <= 1'b0;
            sb_hit_o    <= 1'b0;
            rf_we_o     <= 1'b0;
            merge_o     <= 1'b0;
            drain_o     <= 1'b0;
        end else begin
            // Drain path is independent of the pipeline stall
            drain_o <= drain_i.drain && drain_i.valid;
            if (stall_i) begin
                mem_rd_o <= 1'b0;
                rf_we_o  <= 1'b0;
                merge_o  <= 1'b0;
            end else begin
                // Forwarded loads skip the cache read
                mem_rd_o    <= req_i.rd && !sb_hit_i;
                cache_hit_o <= cache_hit_i;
                sb_hit_o    <= sb_hit_i;
                rf_we_o     <= rf_we_i;
                merge_o     <= drain_i.merge;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            addr_o      <= req_i.addr;
            index_o     <= index_i;
            load_data_o <= load_data_i;
            rf_waddr_o  <= rf_waddr_i;
        end
        drain_addr_o <= drain_i.addr;
        drain_data_o <= drain_i.data;
        drain_size_o <= drain_i.size;
    end

endmodule

`default_nettype wire

//--- hw/tl_hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tl_hazard_ctrl (
    input  wire logic  clk_i,
    input  wire logic  arst_n_i,
    tl_req_if.sink     req_i,
    input  wire logic  cache_hit_i,
    input  wire logic  sb_hit_i,
    tl_drain_if.ctrl   drain_io,
    input  wire logic  store_permission_i,
    input  wire logic  fill_i,
    output logic       stall_o,
    output logic       miss_o
);
    import tl_pkg::*;

    tl_state_e state_q;
    tl_state_e state_d;

    always_comb begin
        state_d        = state_q;
        stall_o        = 1'b0;
        miss_o         = 1'b0;
        drain_io.drain = 1'b0;
        case (state_q)
            TL_IDLE: begin
                if (req_i.rd && !cache_hit_i && !sb_hit_i) begin
                    // Load served by neither cache nor buffer
                    stall_o = 1'b1;
                    miss_o  = 1'b1;
                    state_d = HAZARD_DC_MISS;
                end else if (req_i.wr && drain_io.full && !drain_io.merge) begin
                    stall_o = 1'b1;
                    state_d = HAZARD_SB_FULL;
                end else if (!req_i.rd && !req_i.wr) begin
                    // Buffer may drain in an idle slot
                    drain_io.drain = store_permission_i;
                end
            end
            HAZARD_DC_MISS: begin
                stall_o = 1'b1;
                if (fill_i) begin
                    state_d = TL_IDLE;
                end
            end
            HAZARD_SB_FULL: begin
                stall_o        = 1'b1;
                drain_io.drain = store_permission_i;
                // A drain this cycle frees a slot on the coming edge
                if (store_permission_i && drain_io.valid) begin
                    state_d = TL_IDLE;
                end
            end
            default: begin
                state_d = TL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "tl_defs.svh"

module store_buffer (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    tl_req_if.sink         req_i,
    input  wire logic      stall_i,
    tl_drain_if.buffer     drain_io,
    output logic           hit_o,
    output tl_pkg::data_t  load_data_o
);
    import tl_pkg::*;

    localparam int Depth = `TL_SB_DEPTH;

    // Entries pack from slot 0 upward with the oldest in slot 0
    logic [Depth-1:0] vld_q;
    logic [Depth-1:0] vld_d;
    addr_t            addr_q [Depth];
    addr_t            addr_d [Depth];
    data_t            data_q [Depth];
    data_t            data_d [Depth];
    mem_size_e        size_q [Depth];
    mem_size_e        size_d [Depth];

    logic [Depth-1:0] match;
    logic             do_drain;
    logic             do_merge;
    logic             do_append;

    // Exact address and size match against every live entry
    always_comb begin
        for (int i = 0; i < Depth; i++) begin
            match[i] = vld_q[i] && (addr_q[i] == req_i.addr) && (size_q[i] == req_i.size);
        end
    end

    assign hit_o          = req_i.rd && (|match);
    assign drain_io.merge = req_i.wr && (|match);

    // Later slots are newer and override earlier matches
    always_comb begin
        load_data_o = '0;
        for (int i = 0; i < Depth; i++) begin
            if (match[i]) begin
                load_data_o = data_q[i];
            end
        end
    end

    assign do_drain  = drain_io.drain && vld_q[0];
    assign do_merge  = drain_io.merge && !stall_i;
    assign do_append = req_i.wr && !(|match) && !stall_i;

    // Merge on current slots, then drain shift, then append at first free slot
    always_comb begin
        int ins;
        vld_d  = vld_q;
        addr_d = addr_q;
        data_d = data_q;
        size_d = size_q;
        ins    = Depth - 1;
        for (int i = 0; i < Depth; i++) begin
            if (do_merge && match[i]) begin
                data_d[i] = req_i.data;
            end
        end
        if (do_drain) begin
            for (int i = 0; i < Depth - 1; i++) begin
                vld_d[i]  = vld_d[i+1];
                addr_d[i] = addr_d[i+1];
                data_d[i] = data_d[i+1];
                size_d[i] = size_d[i+1];
            end
            vld_d[Depth-1] = 1'b0;
        end
        for (int i = Depth - 1; i >= 0; i--) begin
            if (!vld_d[i]) begin
                ins = i;
            end
        end
        if (do_append && !(&vld_d)) begin
            vld_d[ins]  = 1'b1;
            addr_d[ins] = req_i.addr;
            data_d[ins] = req_i.data;
            size_d[ins] = req_i.size;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= vld_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
        data_q <= data_d;
        size_q <= size_d;
    end

    // Oldest entry is presented for draining
    assign drain_io.valid = vld_q[0];
    assign drain_io.addr  = addr_q[0];
    assign drain_io.data  = data_q[0];
    assign drain_io.size  = size_q[0];
    assign drain_io.full  = &vld_q;

endmodule

`default_nettype wire

//--- hw/dcache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "tl_defs.svh"

module dcache_tag_array (
    input  wire logic           clk_i,
    input  wire logic           arst_n_i,
    tl_req_if.sink              req_i,
    input  wire logic           fill_i,
    input  wire tl_pkg::addr_t  fill_addr_i,
    output logic                hit_o,
    output tl_pkg::index_t      index_o
);
    import tl_pkg::*;

    localparam int NumLines = 1 << `TL_INDEX_W;
    localparam int TagLsb   = `TL_OFFSET_W + `TL_INDEX_W;

    logic [NumLines-1:0] valid_q;
    tag_t                tag_q [NumLines];

    index_t req_index;
    tag_t   req_tag;
    index_t fill_index;
    tag_t   fill_tag;

    // Split the request and fill addresses into index and tag
    assign req_index  = req_i.addr[`TL_OFFSET_W +: `TL_INDEX_W];
    assign req_tag    = req_i.addr[`TL_ADDR_W-1:TagLsb];
    assign fill_index = fill_addr_i[`TL_OFFSET_W +: `TL_INDEX_W];
    assign fill_tag   = fill_addr_i[`TL_ADDR_W-1:TagLsb];

    assign index_o = req_index;

    // Lookup hits only for an active request
    assign hit_o = (req_i.rd || req_i.wr)
                   && valid_q[req_index]
                   && (tag_q[req_index] == req_tag);

    // Valid bit set by a fill of its line
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_index] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/tl_if.sv
`timescale 1ns/100ps
`default_nettype none

// Load or store request coming from execute
interface tl_req_if;
    import tl_pkg::*;

    logic      rd;
    logic      wr;
    addr_t     addr;
    data_t     data;
    mem_size_e size;

    modport sink (
        input rd,
        input wr,
        input addr,
        input data,
        input size
    );

endinterface

// Store buffer drain path toward the cache
interface tl_drain_if;
    import tl_pkg::*;

    logic      drain;
    logic      valid;
    addr_t     addr;
    data_t     data;
    mem_size_e size;
    logic      merge;
    logic      full;

    modport ctrl (output drain, input valid, input merge, input full);

    modport buffer (
        input  drain,
        output valid,
        output addr,
        output data,
        output size,
        output merge,
        output full
    );

    modport sink (input drain, input valid, input addr, input data, input size, input merge);

endinterface

`default_nettype wire

//--- hw/tl_pkg.sv
`default_nettype none

`include "tl_defs.svh"

package tl_pkg;

    // Byte address and data word
    typedef logic [`TL_ADDR_W-1:0] addr_t;
    typedef logic [`TL_DATA_W-1:0] data_t;

    // Line index into the tag array
    typedef logic [`TL_INDEX_W-1:0] index_t;

    // Address bits above index and offset
    typedef logic [`TL_ADDR_W-`TL_INDEX_W-`TL_OFFSET_W-1:0] tag_t;

    typedef logic [`TL_REG_W-1:0] reg_addr_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    // Hazard controller state
    typedef enum logic [1:0] {
        TL_IDLE,
        HAZARD_DC_MISS,
        HAZARD_SB_FULL
    } tl_state_e;

endpackage

`default_nettype wire

//--- include/tl_defs.svh
`ifndef TL_DEFS_SVH
`define TL_DEFS_SVH

// Byte address and data word widths
`define TL_ADDR_W 32
`define TL_DATA_W 32

// 16-byte lines
`define TL_OFFSET_W 4

// 16 lines in the direct-mapped tag array
`define TL_INDEX_W 4

// Store buffer entries
`define TL_SB_DEPTH 2

// Register file address width
`define TL_REG_W 5

`endif
